/* live_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module live_ring
    import ring_ckpt_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire               push,
    input  wire [BYTE_W-1:0]  push_data,
    input  wire live_copy_t   live_copy,
    output logic [BYTE_W-1:0] copy_rdata,
    output logic              out_valid,
    output logic [BYTE_W-1:0] out_data
);

    logic [BYTE_W-1:0]  ring [RING_DEPTH];
    logic [RING_AW-1:0] ptr;

    // Copy port read is combinational
    assign copy_rdata = ring[live_copy.addr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage and pointer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < RING_DEPTH; i++) begin
                ring[i] <= BYTE_W'(RESET_BASE + i);
            end
            ptr       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= push;
            if (push) begin
                ring[ptr] <= push_data;
                // Natural wrap gives modulo RING_DEPTH
                ptr       <= ptr + 1'b1;
            end
            // Sequencer never overlaps a copy write with a push
            if (live_copy.we) begin
                ring[live_copy.addr] <= live_copy.wdata;
            end
        end
    end

    // Evicted byte is sampled before the new byte lands
    always_ff @(posedge clk) begin
        if (push) begin
            out_data <= ring[ptr];
        end
    end

endmodule

`default_nettype wire

/* ring_ckpt_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ring_ckpt_ctrl
    import ring_ckpt_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire               cmd_valid,
    input  wire ring_cmd_t    cmd,
    output logic              push,
    output logic [BYTE_W-1:0] push_data,
    output live_copy_t        live_copy,
    input  wire [BYTE_W-1:0]  live_rdata,
    output shadow_acc_t       shadow_acc,
    input  wire [BYTE_W-1:0]  shadow_rdata,
    output logic              busy,
    output logic              done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SAVE,
        ST_RESTORE
    } state_e;

    state_e             state;
    logic [RING_AW-1:0] step;
    logic [RING_AW-1:0] step_d;
    logic [PAGE_AW-1:0] page_q;
    logic               arm;
    logic               arm_restore;
    logic               tail;
    logic               take;
    logic               last_step;

    assign busy      = (state != ST_IDLE);
    // A copy that is armed but not yet running still blocks new commands
    assign take      = cmd_valid && !busy && !arm;
    assign last_step = (step == RING_AW'(RING_DEPTH - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            push        <= 1'b0;
            arm         <= 1'b0;
            arm_restore <= 1'b0;
        end else begin
            push <= 1'b0;
            arm  <= 1'b0;
            if (take) begin
                case (cmd.op)
                    OP_PUSH: begin
                        push <= 1'b1;
                    end
                    OP_SAVE, OP_RESTORE: begin
                        arm         <= 1'b1;
                        arm_restore <= (cmd.op == OP_RESTORE);
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && cmd.op == OP_PUSH) begin
            push_data <= cmd.arg.data;
        end
        if (take && (cmd.op == OP_SAVE || cmd.op == OP_RESTORE)) begin
            page_q <= cmd.arg.pg.page;
        end
        // Restore writes trail the bank read address by one cycle
        step_d <= step;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Copy sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            step  <= '0;
            tail  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (arm) begin
                        state <= arm_restore ? ST_RESTORE : ST_SAVE;
                    end
                end
                ST_SAVE: begin
                    step <= step + 1'b1;
                    if (last_step) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                ST_RESTORE: begin
                    if (tail) begin
                        // Last ring write lands in this cycle
                        tail  <= 1'b0;
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end else begin
                        step <= step + 1'b1;
                        if (last_step) begin
                            tail <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Step wraps to zero in the tail cycle, so every restore cycle but the first writes
    always_comb begin
        shadow_acc.we    = (state == ST_SAVE);
        shadow_acc.page  = page_q;
        shadow_acc.addr  = step;
        shadow_acc.wdata = live_rdata;

        live_copy.we    = (state == ST_RESTORE) && (tail || step != '0);
        live_copy.addr  = (state == ST_RESTORE) ? step_d : step;
        live_copy.wdata = shadow_rdata;
    end

endmodule

`default_nettype wire

/* ring_ckpt_pkg.sv */
`default_nettype none

package ring_ckpt_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int RING_DEPTH = 128;
    localparam int RING_AW    = 7;
    localparam int PAGE_COUNT = 16;
    localparam int PAGE_AW    = 4;
    localparam int BYTE_W     = 8;

    // Entry i comes out of reset as RESET_BASE + i
    localparam int RESET_BASE = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        OP_PUSH    = 2'd0,
        OP_SAVE    = 2'd1,
        OP_RESTORE = 2'd2
    } ring_op_e;

    typedef struct packed {
        logic [BYTE_W-PAGE_AW-1:0] rsvd;
        logic [PAGE_AW-1:0]        page;
    } ring_page_t;

    // Data byte for a push, page number for save and restore
    typedef union packed {
        logic [BYTE_W-1:0] data;
        ring_page_t        pg;
    } ring_arg_u;

    typedef struct packed {
        ring_op_e  op;
        ring_arg_u arg;
    } ring_cmd_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic               we;
        logic [RING_AW-1:0] addr;
        logic [BYTE_W-1:0]  wdata;
    } live_copy_t;

    typedef struct packed {
        logic               we;
        logic [PAGE_AW-1:0] page;
        logic [RING_AW-1:0] addr;
        logic [BYTE_W-1:0]  wdata;
    } shadow_acc_t;

endpackage

`default_nettype wire

/* ring_ckpt_top.f */
ring_ckpt_pkg.sv
ring_ckpt_ctrl.sv
live_ring.sv
shadow_bank.sv
ring_ckpt_top.sv
tb_ring_ckpt.sv

/* ring_ckpt_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ring_ckpt_top
    import ring_ckpt_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire               cmd_valid,
    input  wire ring_cmd_t    cmd,
    output logic              out_valid,
    output logic [BYTE_W-1:0] out_data,
    output logic              busy,
    output logic              done
);

    logic              push;
    logic [BYTE_W-1:0] push_data;
    live_copy_t        live_copy;
    logic [BYTE_W-1:0] live_rdata;
    shadow_acc_t       shadow_acc;
    logic [BYTE_W-1:0] shadow_rdata;

    ring_ckpt_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .push         (push),
        .push_data    (push_data),
        .live_copy    (live_copy),
        .live_rdata   (live_rdata),
        .shadow_acc   (shadow_acc),
        .shadow_rdata (shadow_rdata),
        .busy         (busy),
        .done         (done)
    );

    live_ring u_ring (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_data  (push_data),
        .live_copy  (live_copy),
        .copy_rdata (live_rdata),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

    shadow_bank u_bank (
        .clk        (clk),
        .reset      (reset),
        .shadow_acc (shadow_acc),
        .rdata      (shadow_rdata)
    );

endmodule

`default_nettype wire

/* shadow_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module shadow_bank
    import ring_ckpt_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire shadow_acc_t  shadow_acc,
    output logic [BYTE_W-1:0] rdata
);

    localparam int BANK_DEPTH = PAGE_COUNT * RING_DEPTH;

    logic [BYTE_W-1:0]          mem [BANK_DEPTH];
    logic [PAGE_AW+RING_AW-1:0] addr;

    // Page selects the upper address bits
    assign addr = {shadow_acc.page, shadow_acc.addr};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Page storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (shadow_acc.we) begin
            mem[addr] <= shadow_acc.wdata;
        end
    end

    // Registered read of the addressed byte on every cycle
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* tb_ring_ckpt.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ring_ckpt
    import ring_ckpt_pkg::*;
();

    logic               clk;
    logic               reset;
    logic               cmd_valid;
    ring_cmd_t          cmd;
    logic               out_valid;
    logic [BYTE_W-1:0]  out_data;
    logic               busy;
    logic               done;

    logic [15:0]        lfsr;
    logic [BYTE_W-1:0]  ref_ring [RING_DEPTH];
    logic [BYTE_W-1:0]  ref_page [PAGE_COUNT][RING_DEPTH];
    logic               saved [PAGE_COUNT];
    logic [RING_AW-1:0] ref_ptr;
    logic [BYTE_W-1:0]  exp_data [$];
    int                 exp_cyc [$];
    int                 cyc = 0;
    int                 errors = 0;
    int                 done_seen = 0;
    int                 tests_pass = 0;
    int                 tests_fail = 0;
    logic               prev_busy = 1'b0;

    ring_ckpt_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .out_valid (out_valid),
        .out_data  (out_data),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus source and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [BYTE_W-1:0] rand_bits(input int n);
        logic [BYTE_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[BYTE_W-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Oldest byte leaves, new byte takes its slot, pointer wraps at 128
    function automatic logic [BYTE_W-1:0] ref_push(input logic [BYTE_W-1:0] b);
        logic [BYTE_W-1:0] evicted;
        evicted           = ref_ring[ref_ptr];
        ref_ring[ref_ptr] = b;
        ref_ptr           = RING_AW'((ref_ptr + 1) % RING_DEPTH);
        return evicted;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!reset) begin
            if (done) begin
                done_seen++;
                if (busy || !prev_busy) begin
                    $display("done pulsed at cycle %0d without busy falling", cyc);
                    errors++;
                end
            end
            prev_busy = busy;
            if (out_valid) begin
                if (exp_data.size() == 0) begin
                    $display("out_valid rose at cycle %0d with no push outstanding", cyc);
                    errors++;
                end else begin
                    if (out_data !== exp_data[0]) begin
                        $display("ERROR out_data expected 0x%02h got 0x%02h",
                                 exp_data[0], out_data);
                        errors++;
                    end
                    if (cyc != exp_cyc[0]) begin
                        $display("out_valid came at cycle %0d, due at cycle %0d",
                                 cyc, exp_cyc[0]);
                        errors++;
                    end
                    void'(exp_data.pop_front());
                    void'(exp_cyc.pop_front());
                end
            end else if (exp_cyc.size() != 0 && exp_cyc[0] <= cyc) begin
                $display("out_valid missing for a push due at cycle %0d", exp_cyc[0]);
                errors++;
                void'(exp_data.pop_front());
                void'(exp_cyc.pop_front());
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic send_cmd(input logic [1:0] op, input logic [BYTE_W-1:0] arg);
        @(negedge clk);
        cmd_valid    = 1'b1;
        cmd.op       = ring_op_e'(op);
        cmd.arg.data = arg;
    endtask

    task automatic release_cmd();
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic push_byte(input logic [BYTE_W-1:0] b, input bit taken);
        send_cmd(OP_PUSH, b);
        if (taken) begin
            exp_data.push_back(ref_push(b));
            exp_cyc.push_back(cyc + 2);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_data.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > 10) begin
                abort_run("pushed bytes never came back on out_data");
            end
        end
    endtask

    // gap = 0 gives one push per cycle
    task automatic push_burst(input int n, input bit gap);
        for (int i = 0; i < n; i++) begin
            push_byte(rand_bits(BYTE_W), 1'b1);
            if (gap) begin
                release_cmd();
            end
        end
        if (!gap) begin
            release_cmd();
        end
        drain();
    endtask

    task automatic run_copy(input logic [1:0] op, input logic [PAGE_AW-1:0] page,
                            input int drops);
        int n;
        int seen;
        seen = done_seen;
        // Reserved bits carry noise that the page view ignores
        send_cmd(op, (rand_bits(BYTE_W - PAGE_AW) << PAGE_AW) | page);
        for (int i = 0; i < RING_DEPTH; i++) begin
            if (op == OP_SAVE) begin
                ref_page[page][i] = ref_ring[i];
            end else begin
                ref_ring[i] = ref_page[page][i];
            end
        end
        if (op == OP_SAVE) begin
            saved[page] = 1'b1;
        end
        release_cmd();
        n = 0;
        while (!busy) begin
            @(negedge clk);
            n++;
            if (n > 5) begin
                abort_run("busy never rose after a copy command");
            end
        end
        for (int i = 0; i < drops; i++) begin
            push_byte(rand_bits(BYTE_W), 1'b0);
            if (!busy) begin
                $display("busy fell before a dropped push was issued");
                errors++;
            end
        end
        release_cmd();
        n = 0;
        while (!done) begin
            @(negedge clk);
            n++;
            if (n > 200) begin
                abort_run("done never pulsed after a copy");
            end
        end
        @(negedge clk);
        if (done || busy || done_seen != seen + 1) begin
            $display("copy did not end with a single done pulse and busy low");
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err0);
        @(posedge clk);
        if (errors == err0) begin
            tests_pass++;
            $display("%s: ok", name);
        end else begin
            tests_fail++;
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int                 err0;
        logic [PAGE_AW-1:0] pa;
        logic [PAGE_AW-1:0] pb;
        logic [PAGE_AW-1:0] pc;
        lfsr      = 16'd54539;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        ref_ptr   = '0;
        for (int i = 0; i < RING_DEPTH; i++) begin
            ref_ring[i] = BYTE_W'(RESET_BASE + i);
        end
        for (int p = 0; p < PAGE_COUNT; p++) begin
            saved[p] = 1'b0;
            for (int i = 0; i < RING_DEPTH; i++) begin
                ref_page[p][i] = '0;
            end
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        if (out_valid || busy || done) begin
            $display("outputs were not low after reset");
            errors++;
        end

        // Reset contents come out first, then the first random bytes
        err0 = errors;
        push_burst(RING_DEPTH, 1'b1);
        push_burst(RING_DEPTH, 1'b1);
        end_test("reset contents and wrap", err0);

        err0 = errors;
        // Move the pointer off zero so the copies have to keep it
        push_burst(1 + rand_bits(6), 1'b1);
        pa   = rand_bits(PAGE_AW);
        run_copy(OP_SAVE, pa, 0);
        push_burst(RING_DEPTH, 1'b0);
        run_copy(OP_RESTORE, pa, 0);
        push_burst(RING_DEPTH, 1'b1);
        end_test("save, push, restore", err0);

        err0 = errors;
        pa   = rand_bits(PAGE_AW);
        pb   = pa + PAGE_AW'(1 + rand_bits(3));
        run_copy(OP_SAVE, pa, 0);
        push_burst(RING_DEPTH, 1'b1);
        run_copy(OP_SAVE, pb, 0);
        push_burst(RING_DEPTH, 1'b1);
        run_copy(OP_RESTORE, pb, 0);
        push_burst(RING_DEPTH, 1'b1);
        run_copy(OP_RESTORE, pa, 0);
        push_burst(RING_DEPTH, 1'b1);
        pc = '0;
        for (int p = PAGE_COUNT - 1; p >= 0; p--) begin
            if (!saved[p]) begin
                pc = PAGE_AW'(p);
            end
        end
        run_copy(OP_RESTORE, pc, 0);
        push_burst(RING_DEPTH, 1'b1);
        end_test("two pages and an empty page", err0);

        err0 = errors;
        run_copy(OP_SAVE, rand_bits(PAGE_AW), 8);
        send_cmd(2'd3, rand_bits(BYTE_W));
        release_cmd();
        // A started copy shows busy one cycle after it is armed
        @(negedge clk);
        if (busy || done) begin
            $display("reserved op started a copy");
            errors++;
        end
        push_burst(RING_DEPTH, 1'b1);
        end_test("dropped and reserved commands", err0);

        err0 = errors;
        push_burst(200, 1'b0);
        pa = rand_bits(PAGE_AW);
        run_copy(OP_SAVE, pa, 0);
        run_copy(OP_RESTORE, pa, 0);
        push_burst(RING_DEPTH, 1'b0);
        end_test("back-to-back pushes and done pulses", err0);

        $display("Summary: %0d tests ok, %0d tests with errors", tests_pass, tests_fail);
        if (errors == 0 && tests_fail == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
